// File: fat_pkg.sv
/*
 * Shared types and constants for the FAT32 file reader.
 * Every design file imports this package in its module header.
 */
package fat_pkg;

    localparam int sector_bytes = 512;
    localparam int dir_entry_bytes = 32;
    localparam int fat_entry_bytes = 4;
    localparam logic [31:0] eoc_min = 32'h0FFF_FFF8;
    localparam int name_len = 11;  // 8.3 short name, space padded

    typedef logic [31:0] lba_t;
    typedef logic [31:0] cluster_t;

    // one byte arriving from the block device
    typedef struct packed {
        logic       valid;
        logic [8:0] addr;  // byte position within the sector
        logic [7:0] data;
    } byte_strobe_t;

    typedef struct packed {
        logic       valid;
        logic [7:0] sectors_per_cluster;
        lba_t       fat_start;
        lba_t       data_start;  // already moved back by two clusters
        cluster_t   root_cluster;
    } volume_geom_t;

    typedef struct packed {
        logic       found;
        cluster_t   first_cluster;
        logic [31:0] file_size;
    } dir_hit_t;

    typedef struct packed {
        logic done;
        logic file_found;
        logic bad_volume;
    } reader_status_t;

    // last cluster of a chain, or a free/reserved entry that cannot continue it
    function automatic logic is_end_of_chain(input cluster_t entry);
        cluster_t masked;
        masked = entry & 32'h0FFF_FFFF;  // top nibble is reserved
        return (masked >= eoc_min) || (masked < 2);
    endfunction

endpackage

// File: boot_sector_parser.sv
/*
 * Picks the MBR partition entry and the FAT32 boot-sector fields out of the
 * sector byte stream and turns them into the volume geometry.
 */
module boot_sector_parser import fat_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  byte_strobe_t sec_byte,
    input  logic         phase_boot,
    input  logic         phase_mbr,
    input  lba_t         sector_lba,
    output volume_geom_t geom,
    output lba_t         mbr_target,
    output logic         is_mbr,
    output logic         sector_ok
);

    logic        capture;
    logic [7:0]  jump_op;
    logic [7:0]  oem_b1;
    logic [15:0] signature;
    logic [15:0] bps;
    logic [7:0]  spc;
    logic [15:0] resv;
    logic [7:0]  nfat;
    logic [31:0] spf;
    cluster_t    root_clus;
    lba_t        part_lba;
    lba_t        fat_start_q;
    lba_t        data_start_q;
    logic        sig_ok;
    logic        jump_ok;

    // sector 0 is parsed as a boot sector too, in case there is no MBR
    assign capture = sec_byte.valid && (phase_boot || phase_mbr);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            jump_op   <= '0;
            signature <= '0;
        end else if (capture) begin
            if (sec_byte.addr == 9'h000) jump_op <= sec_byte.data;
            if (sec_byte.addr == 9'h1FE) signature[7:0] <= sec_byte.data;
            if (sec_byte.addr == 9'h1FF) signature[15:8] <= sec_byte.data;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            case (sec_byte.addr) inside
                9'h001:            oem_b1 <= sec_byte.data;
                9'h00B:            bps[7:0] <= sec_byte.data;
                9'h00C:            bps[15:8] <= sec_byte.data;
                9'h00D:            spc <= sec_byte.data;
                9'h00E:            resv[7:0] <= sec_byte.data;
                9'h00F:            resv[15:8] <= sec_byte.data;
                9'h010:            nfat <= sec_byte.data;
                [9'h024:9'h027]:   spf[8*sec_byte.addr[1:0] +: 8] <= sec_byte.data;
                [9'h02C:9'h02F]:   root_clus[8*sec_byte.addr[1:0] +: 8] <= sec_byte.data;
                default: ;
            endcase
            if (phase_mbr && sec_byte.addr inside {[9'h1C6:9'h1C9]}) begin
                part_lba[8*2'(sec_byte.addr - 9'h1C6) +: 8] <= sec_byte.data;  // entry 0 start
            end
        end
        if (phase_boot || phase_mbr) begin
            fat_start_q  <= sector_lba + lba_t'(resv);
            data_start_q <= fat_start_q + spf * lba_t'(nfat) - lba_t'(spc) * 2;
        end
    end

    assign sig_ok  = (signature == 16'hAA55);
    assign jump_ok = (jump_op == 8'hEB) || (jump_op == 8'hE9);
    assign is_mbr  = sig_ok && !jump_ok;  // signed but no jump means partition table
    assign sector_ok = sig_ok && jump_ok && (oem_b1 == 8'h58)
                       && (bps == 16'(sector_bytes));

    assign mbr_target = part_lba;
    assign geom = '{valid: sector_ok,
                    sectors_per_cluster: spc,
                    fat_start: fat_start_q,
                    data_start: data_start_q,
                    root_cluster: root_clus};

endmodule

// File: dir_entry_matcher.sv
/*
 * Scans 32-byte root-directory entries as they stream past and latches the
 * first live file entry whose short name matches file_name, case folded.
 */
module dir_entry_matcher import fat_pkg::*; #(
    parameter logic [8*name_len-1:0] file_name = "README  TXT"
) (
    input  logic         clk,
    input  logic         rst_n,
    input  byte_strobe_t sec_byte,
    input  logic         enable,
    output dir_hit_t     hit
);

    logic [$clog2(dir_entry_bytes)-1:0] offset;
    logic        take;
    logic [7:0]  in_char;
    logic [7:0]  name_char;
    logic        names_agree;
    logic        deleted;
    logic [7:0]  attr;
    logic [15:0] clus_hi;
    logic [15:0] clus_lo;
    logic [23:0] size_lo;

    function automatic logic [7:0] to_upper(input logic [7:0] c);
        return (c >= "a" && c <= "z") ? (c & 8'hDF) : c;
    endfunction

    assign offset  = sec_byte.addr[$clog2(dir_entry_bytes)-1:0];
    assign take    = enable && sec_byte.valid;
    assign in_char = to_upper(sec_byte.data);

    always_comb begin
        name_char = 8'h00;
        if (offset < name_len) begin
            name_char = to_upper(file_name[8*(name_len-1-offset) +: 8]);  // first char is msb
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            names_agree <= 1'b0;
            deleted     <= 1'b0;
            attr        <= '0;
            hit         <= '0;
        end else if (take) begin
            if (offset == 0) begin
                names_agree <= (in_char == name_char);
                deleted     <= (sec_byte.data == 8'hE5);
            end else if (offset < name_len) begin
                names_agree <= names_agree && (in_char == name_char);
            end
            if (offset == name_len) attr <= sec_byte.data;  // attribute follows the name
            // volume label and subdirectory bits rule the entry out
            if (offset == dir_entry_bytes - 1 && !hit.found && names_agree && !deleted
                && (attr & 8'h18) == 8'h00) begin
                hit.found         <= 1'b1;
                hit.first_cluster <= {clus_hi, clus_lo};
                hit.file_size     <= {sec_byte.data, size_lo};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            case (offset)
                5'd20:   clus_hi[7:0] <= sec_byte.data;
                5'd21:   clus_hi[15:8] <= sec_byte.data;
                5'd26:   clus_lo[7:0] <= sec_byte.data;
                5'd27:   clus_lo[15:8] <= sec_byte.data;
                5'd28:   size_lo[7:0] <= sec_byte.data;
                5'd29:   size_lo[15:8] <= sec_byte.data;
                5'd30:   size_lo[23:16] <= sec_byte.data;
                default: ;
            endcase
        end
    end

endmodule

// File: cluster_walker.sv
/*
 * Main sequencer. Issues four-phase sector requests through MBR, boot sector,
 * root-directory chain and file chain, reads FAT entries between clusters
 * and forwards at most file-size bytes of file data.
 */
module cluster_walker import fat_pkg::*; (
    input  logic           clk,
    input  logic           rst_n,
    output logic           sec_req,
    output lba_t           sec_lba,
    input  logic           sec_ack,
    input  byte_strobe_t   sec_byte,
    input  volume_geom_t   geom,
    input  lba_t           mbr_target,
    input  logic           is_mbr,
    input  logic           sector_ok,
    input  dir_hit_t       hit,
    output logic           phase_mbr,
    output logic           phase_boot,
    output logic           phase_dir,
    output logic           out_valid,
    output logic [7:0]     out_byte,
    output reader_status_t status
);

    typedef enum logic [2:0] {
        st_idle,
        st_probe,
        st_boot,
        st_root,
        st_file,
        st_fat,
        st_done
    } walk_state_t;

    walk_state_t state;
    walk_state_t ret_state;  // chain to resume after a FAT lookup
    cluster_t    cluster;
    logic [7:0]  sec_off;
    logic [31:0] byte_cnt;
    cluster_t    fat_entry;
    logic        done_q;
    logic        bad_q;
    lba_t        data_lba;
    lba_t        fat_lba;
    logic        fat_take;
    logic        file_take;
    logic        last_sector;

    assign data_lba = geom.data_start + lba_t'(cluster * geom.sectors_per_cluster)
                      + lba_t'(sec_off);
    assign fat_lba  = geom.fat_start + lba_t'(cluster / (sector_bytes / fat_entry_bytes));
    assign last_sector = (sec_off == geom.sectors_per_cluster - 8'd1);

    // only the four bytes of the current cluster's entry
    assign fat_take = (state == st_fat) && sec_byte.valid
                      && (sec_byte.addr / fat_entry_bytes)
                         == (cluster % (sector_bytes / fat_entry_bytes));
    assign file_take = (state == st_file) && sec_byte.valid && (byte_cnt < hit.file_size);

    always_comb begin
        case (state)
            st_boot:          sec_lba = mbr_target;
            st_root, st_file: sec_lba = data_lba;
            st_fat:           sec_lba = fat_lba;
            default:          sec_lba = '0;  // probe reads sector 0
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= st_idle;
            ret_state <= st_root;
            sec_req   <= 1'b0;
            cluster   <= '0;
            sec_off   <= '0;
            byte_cnt  <= '0;
            done_q    <= 1'b0;
            bad_q     <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= file_take;
            if (file_take) byte_cnt <= byte_cnt + 32'd1;
            if (state == st_idle) begin
                state <= st_probe;
            end else if (!sec_req && !sec_ack && state != st_done) begin
                sec_req <= 1'b1;  // previous ack has dropped
            end else if (sec_req && sec_ack) begin
                sec_req <= 1'b0;
                case (state)
                    st_probe, st_boot: begin
                        if (state == st_probe && is_mbr) begin
                            state <= st_boot;
                        end else if (sector_ok) begin
                            state   <= st_root;
                            cluster <= geom.root_cluster;
                            sec_off <= '0;
                        end else begin
                            state  <= st_done;
                            done_q <= 1'b1;
                            bad_q  <= 1'b1;
                        end
                    end
                    st_root, st_file: begin
                        if (state == st_root && hit.found) begin
                            if (is_end_of_chain(hit.first_cluster)) begin
                                state  <= st_done;  // empty file owns no cluster
                                done_q <= 1'b1;
                            end else begin
                                state   <= st_file;
                                cluster <= hit.first_cluster;
                                sec_off <= '0;
                            end
                        end else if (last_sector) begin
                            ret_state <= state;
                            state     <= st_fat;
                        end else begin
                            sec_off <= sec_off + 8'd1;
                        end
                    end
                    st_fat: begin
                        if (is_end_of_chain(fat_entry)) begin
                            state  <= st_done;
                            done_q <= 1'b1;
                        end else begin
                            cluster <= fat_entry & 32'h0FFF_FFFF;
                            sec_off <= '0;
                            state   <= ret_state;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fat_take) fat_entry[8*(sec_byte.addr % fat_entry_bytes) +: 8] <= sec_byte.data;
        if (file_take) out_byte <= sec_byte.data;
    end

    assign phase_mbr  = (state == st_probe);
    assign phase_boot = (state == st_boot);
    assign phase_dir  = (state == st_root);
    assign status = '{done: done_q, file_found: hit.found, bad_volume: bad_q};

endmodule

// File: fat_file_reader.sv
/*
 * Top level of the FAT32 file reader. Connect sec_req/sec_lba/sec_ack/sec_byte
 * to a block device; the named file then streams out on out_valid/out_byte.
 */
module fat_file_reader import fat_pkg::*; #(
    parameter logic [8*name_len-1:0] file_name = "README  TXT"
) (
    input  logic           clk,
    input  logic           rst_n,
    output logic           sec_req,
    output lba_t           sec_lba,
    input  logic           sec_ack,
    input  byte_strobe_t   sec_byte,
    output logic           out_valid,
    output logic [7:0]     out_byte,
    output reader_status_t status
);

    volume_geom_t geom;
    lba_t         mbr_target;
    logic         is_mbr;
    logic         sector_ok;
    dir_hit_t     hit;
    logic         phase_mbr;
    logic         phase_boot;
    logic         phase_dir;

    boot_sector_parser i_boot_sector_parser (
        .clk        (clk),
        .rst_n      (rst_n),
        .sec_byte   (sec_byte),
        .phase_boot (phase_boot),
        .phase_mbr  (phase_mbr),
        .sector_lba (sec_lba),
        .geom       (geom),
        .mbr_target (mbr_target),
        .is_mbr     (is_mbr),
        .sector_ok  (sector_ok)
    );

    dir_entry_matcher #(
        .file_name (file_name)
    ) i_dir_entry_matcher (
        .clk      (clk),
        .rst_n    (rst_n),
        .sec_byte (sec_byte),
        .enable   (phase_dir),
        .hit      (hit)
    );

    cluster_walker i_cluster_walker (
        .clk        (clk),
        .rst_n      (rst_n),
        .sec_req    (sec_req),
        .sec_lba    (sec_lba),
        .sec_ack    (sec_ack),
        .sec_byte   (sec_byte),
        .geom       (geom),
        .mbr_target (mbr_target),
        .is_mbr     (is_mbr),
        .sector_ok  (sector_ok),
        .hit        (hit),
        .phase_mbr  (phase_mbr),
        .phase_boot (phase_boot),
        .phase_dir  (phase_dir),
        .out_valid  (out_valid),
        .out_byte   (out_byte),
        .status     (status)
    );

endmodule

// File: tb_disk_model.sv
/*
 * Block device for the testbench. build_image lays out a random FAT32 volume
 * in a sparse byte array; the responder answers four-phase sector requests.
 */
module tb_disk_model import fat_pkg::*; (
    input  logic         clk,
    input  logic         sec_req,
    input  lba_t         sec_lba,
    output logic         sec_ack,
    output byte_strobe_t sec_byte
);

    localparam int pool = 300;  // clusters 2 .. pool+1 can be allocated

    bit [7:0]    disk [int unsigned];  // byte address -> data
    bit          used [int unsigned];  // clusters already handed out
    logic [7:0]  file_data [$];        // contents of the target file
    int unsigned sectors;              // upper bound on requests for one run
    int          seed = 32'he3e7;
    int unsigned spc;
    int unsigned data_lba;             // first sector of cluster 2

    function automatic int unsigned rnd(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic logic [7:0] peek(input int unsigned addr);
        return disk.exists(addr) ? disk[addr] : 8'h00;
    endfunction

    function automatic int unsigned clus_addr(input int unsigned c);
        return (data_lba + (c - 2) * spc) * sector_bytes;
    endfunction

    // little endian, as every FAT field is
    task automatic put(input int unsigned addr, input int unsigned nbytes,
                       input logic [31:0] val);
        for (int i = 0; i < nbytes; i++)
            disk[addr + i] = val[8*i +: 8];
    endtask

    task automatic put_entry(input int unsigned addr, input logic [8*name_len-1:0] name,
                             input logic [7:0] attr, input int unsigned clus,
                             input int unsigned size);
        for (int i = 0; i < name_len; i++)
            disk[addr + i] = name[8*(name_len-1-i) +: 8];
        disk[addr + 11] = attr;
        put(addr + 20, 2, clus >> 16);
        put(addr + 26, 2, clus);
        put(addr + 28, 4, size);
    endtask

    // never the cluster right after prev, so chains are fragmented
    function automatic int unsigned alloc(input int unsigned prev);
        int unsigned c;
        do begin
            c = 2 + rnd(pool);
        end while (used.exists(c) || c == prev + 1);
        used[c] = 1'b1;
        return c;
    endfunction

    task automatic build_image(input bit mbr, input int unsigned bps, input int root_idx,
                               input bit present, input bit traps,
                               input logic [8*name_len-1:0] name,
                               input int unsigned min_clus);
        int unsigned part;
        int unsigned resv;
        int unsigned fat_addr;
        int unsigned root [2];
        int unsigned first;
        int unsigned clus;
        int unsigned prev;
        int unsigned size;
        int unsigned nclus;
        disk.delete();
        used.delete();
        file_data.delete();
        part = mbr ? 1 + rnd(63) : 0;
        spc  = 1 << rnd(3);
        resv = 2 + rnd(30);
        data_lba = part + resv + 2 * 3;  // two FATs of three sectors each
        fat_addr = (part + resv) * sector_bytes;
        if (mbr) begin
            disk[0]   = 8'hFA;  // boot code, no jump
            disk[446] = 8'h80;
            disk[450] = 8'h0C;  // FAT32 LBA partition type
            put(454, 4, part);
            put(510, 2, 16'hAA55);
        end
        root[0] = alloc(0);
        root[1] = alloc(root[0]);
        put(part * sector_bytes, 3, 24'h9058EB);
        put(part * sector_bytes + 11, 2, bps);
        disk[part * sector_bytes + 13] = 8'(spc);
        put(part * sector_bytes + 14, 2, resv);
        disk[part * sector_bytes + 16] = 8'd2;
        put(part * sector_bytes + 36, 4, 3);
        put(part * sector_bytes + 44, 4, root[0]);
        put(part * sector_bytes + 510, 2, 16'hAA55);
        put(fat_addr + 4 * root[0], 4, root[1] | (rnd(16) << 28));
        put(fat_addr + 4 * root[1], 4, 32'h0FFF_FFFF);
        for (int i = 0; i < 6; i++)  // unrelated files
            put_entry(clus_addr(root[i % 2]) + 32 * rnd(16 * spc),
                      {"NOTE", 8'(65 + rnd(26)), "   TXT"}, 8'h20, 0, 0);
        size  = (min_clus - 1) * spc * sector_bytes + 1 + rnd(2 * spc * sector_bytes);
        nclus = (size + spc * sector_bytes - 1) / (spc * sector_bytes);
        prev  = 0;
        for (int k = 0; k < nclus; k++) begin
            clus = alloc(prev);
            if (k == 0)
                first = clus;
            else
                put(fat_addr + 4 * prev, 4, clus | (rnd(16) << 28));  // junk top nibble
            for (int b = 0; b < spc * sector_bytes; b++) begin
                disk[clus_addr(clus) + b] = 8'(rnd(256));  // tail past size is junk too
                if (file_data.size() < size)
                    file_data.push_back(disk[clus_addr(clus) + b]);
            end
            prev = clus;
        end
        put(fat_addr + 4 * prev, 4, (32'h0FFF_FFF8 + rnd(8)) | (rnd(16) << 28));
        if (traps) begin
            put_entry(clus_addr(root[0]), {8'hE5, name[79:0]}, 8'h20, pool + 10, 100);
            put_entry(clus_addr(root[0]) + 32, name, 8'h10, pool + 11, 0);  // subdirectory
        end
        if (present)
            put_entry(clus_addr(root[root_idx]) + 32 * rnd(16 * spc), name, 8'h20, first, size);
        sectors = (mbr ? 2 : 1) + 2 * (spc + 1) + nclus * (spc + 1);
    endtask

    initial begin : responder
        lba_t lba;
        sec_ack  = 1'b0;
        sec_byte = '0;
        forever begin
            @(negedge clk);
            if (sec_req && !sec_ack) begin
                lba = sec_lba;
                for (int i = 0; i < sector_bytes; i++) begin
                    repeat (rnd(3)) @(negedge clk);
                    sec_byte = '{valid: 1'b1, addr: 9'(i), data: peek(lba * sector_bytes + i)};
                    @(negedge clk);
                    sec_byte.valid = 1'b0;  // one cycle per byte
                end
                repeat (3 + rnd(6)) @(negedge clk);
                sec_ack = 1'b1;
                do begin
                    @(negedge clk);
                end while (sec_req);
                sec_ack = 1'b0;
            end
        end
    end

endmodule

// File: tb_fat_file_reader.sv
/*
 * Testbench for the FAT32 file reader. Runs six scenarios on random images
 * and checks the reset state, every streamed byte and the final status word.
 */
module tb_fat_file_reader import fat_pkg::*; ();

    localparam logic [8*name_len-1:0] target = "DATA    BIN";

    logic           clk;
    logic           rst_n;
    logic           sec_req;
    lba_t           sec_lba;
    logic           sec_ack;
    byte_strobe_t   sec_byte;
    logic           out_valid;
    logic [7:0]     out_byte;
    reader_status_t status;
    logic [7:0]     exp_q [$];  // file bytes still to arrive
    int             errors = 0;
    int             failed = 0;
    int             tests_run = 0;
    longint         budget = 1000;  // watchdog cycles granted so far

    fat_file_reader #(
        .file_name (target)
    ) i_fat_file_reader (
        .clk       (clk),
        .rst_n     (rst_n),
        .sec_req   (sec_req),
        .sec_lba   (sec_lba),
        .sec_ack   (sec_ack),
        .sec_byte  (sec_byte),
        .out_valid (out_valid),
        .out_byte  (out_byte),
        .status    (status)
    );

    tb_disk_model i_disk_model (
        .clk      (clk),
        .sec_req  (sec_req),
        .sec_lba  (sec_lba),
        .sec_ack  (sec_ack),
        .sec_byte (sec_byte)
    );

    always #5 clk = ~clk;

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t: out_byte is %02h, expected %02h", $time, got, exp);
            errors++;
        end
    endtask

    task automatic check_status(input reader_status_t got, input reader_status_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: status done/found/bad is %b%b%b, expected %b%b%b",
                     $time, got.done, got.file_found, got.bad_volume,
                     exp.done, exp.file_found, exp.bad_volume);
            errors++;
        end
    endtask

    // outputs change on the rising edge, sampled on the falling one
    always @(negedge clk) begin
        if (rst_n && out_valid) begin
            if (exp_q.size() == 0) begin
                $display("out_valid rose at %0t with no file byte left to deliver", $time);
                errors++;
            end else begin
                check_byte(out_byte, exp_q.pop_front());
            end
        end
    end

    task automatic run_test(input int num, input string what, input bit mbr,
                            input int unsigned bps, input int root_idx, input bit present,
                            input bit traps, input logic [8*name_len-1:0] disk_name,
                            input int unsigned min_clus);
        int             errs_before;
        reader_status_t expect_st;
        logic           req_early;
        errs_before = errors;
        rst_n = 1'b0;
        i_disk_model.build_image(mbr, bps, root_idx, present, traps, disk_name, min_clus);
        expect_st = '{done: 1'b1, file_found: present && bps == sector_bytes,
                      bad_volume: bps != sector_bytes};
        exp_q.delete();
        if (expect_st.file_found)
            exp_q = i_disk_model.file_data;
        budget += longint'(i_disk_model.sectors) * sector_bytes * 4 + 200;
        repeat (3) @(negedge clk);
        check_status(status, '0);  // all status bits idle in reset
        if (sec_req !== 1'b0 || out_valid !== 1'b0) begin
            $display("test %0d: sec_req or out_valid is not low during reset", num);
            errors++;
        end
        rst_n = 1'b1;
        @(negedge clk);
        req_early = sec_req;
        @(negedge clk);
        if (req_early !== 1'b0 || sec_req !== 1'b1) begin
            $display("test %0d: sec_req did not first rise on the second clock after reset",
                     num);
            errors++;
        end
        while (!status.done) @(negedge clk);
        repeat (4) @(negedge clk);  // room for a stray byte after done
        check_status(status, expect_st);
        if (exp_q.size() != 0) begin
            $display("test %0d ended with %0d file bytes never delivered", num, exp_q.size());
            errors++;
        end
        tests_run++;
        if (errors != errs_before)
            failed++;
        $display("test %0d (%s): %s", num, what, errors == errs_before ? "passed" : "failed");
    endtask

    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        run_test(1, "mbr, file in first root cluster", 1, 512, 0, 1, 0, target, 1);
        run_test(2, "fragmented multi-cluster file", 1, 512, 0, 1, 0, target, 3);
        run_test(3, "second root cluster, mixed case, decoys", 1, 512, 1, 1, 1,
                 "dAtA    bIn", 1);
        run_test(4, "name absent", 1, 512, 0, 0, 0, target, 1);
        run_test(5, "boot sector at lba 0", 0, 512, 0, 1, 0, target, 2);
        run_test(6, "1024-byte sectors", 1, 1024, 0, 1, 0, target, 1);
        $display("%0d tests run, %0d failed, %0d errors", tests_run, failed, errors);
        if (errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

    initial begin : watchdog
        longint cycles;
        cycles = 0;
        while (cycles <= budget) begin
            @(posedge clk);
            cycles++;
        end
        $display("watchdog expired after %0d cycles, the reader stopped making progress",
                 cycles);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// File: flist.f
fat_pkg.sv
boot_sector_parser.sv
dir_entry_matcher.sv
cluster_walker.sv
fat_file_reader.sv
tb_disk_model.sv
tb_fat_file_reader.sv

// File: Bender.yml
package:
  name: fat_file_reader

sources:
  - fat_pkg.sv
  - boot_sector_parser.sv
  - dir_entry_matcher.sv
  - cluster_walker.sv
  - fat_file_reader.sv
  - target: test
    files:
      - tb_disk_model.sv
      - tb_fat_file_reader.sv
